// File: dcache_pkg.sv
`default_nettype none

package dcache_pkg;

   // --------------------------------------------------
   // Address split.
   // --------------------------------------------------
   localparam int TAG_W     = 26;
   localparam int BYTE_W    = 2;
   localparam int WSEL_BIT  = BYTE_W;
   localparam int INDEX_LSB = BYTE_W + 1;

   localparam logic [31:0] COUNT_ADDR = 32'h0000_3100;

   typedef logic [31:0]      word_t;
   typedef logic [TAG_W-1:0] tag_t;

   // --------------------------------------------------
   // Bus structs.
   // --------------------------------------------------
   typedef struct packed {
      logic  ren;
      logic  wen;
      logic  halt;
      word_t addr;
      word_t store;
   } cache_req_t;

   typedef struct packed {
      logic  hit;
      word_t load;
      logic  flushed;
   } cache_rsp_t;

   typedef struct packed {
      logic  ren;
      logic  wen;
      word_t addr;
      word_t store;
   } mem_req_t;

   typedef struct packed {
      logic  busy;
      word_t load;
   } mem_rsp_t;

   // One way of one set with word 1 in the upper half.
   typedef struct packed {
      logic        valid;
      logic        dirty;
      tag_t        tag;
      word_t [1:0] data;
   } line_t;

   typedef struct packed {
      logic  hit;
      logic  hit_way;
      logic  victim_way;
      logic  victim_dirty;
      tag_t  victim_tag;
      word_t load_word;
   } lookup_t;

   typedef enum logic [2:0] {
      OP_NOP, OP_STORE_HIT, OP_FILL_LO, OP_FILL_HI, OP_CLEAN, OP_TOUCH
   } array_op_e;

   typedef enum logic [3:0] {
      IDLE, WB_LO, WB_HI, FILL_LO, FILL_HI, SCAN, FLUSH_LO, FLUSH_HI, SCORE, HALTED
   } ctrl_state_e;

endpackage

`default_nettype wire

// File: dcache_arrays.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_arrays #(
   parameter int SETS = 8
) (
   input  logic                      CLK,
   input  logic                      nRST,
   input  logic [$clog2(SETS)-1:0]   index,
   input  dcache_pkg::array_op_e     op,
   input  logic                      way,
   input  dcache_pkg::word_t         wdata,
   input  dcache_pkg::tag_t          wtag,
   input  logic                      word_sel,
   output dcache_pkg::line_t         way0,
   output dcache_pkg::line_t         way1,
   output logic                      lru
);
   import dcache_pkg::*;

   localparam int IDX_W = $clog2(SETS);

   line_t [1:0] sets_q [SETS];
   // Each bit names the least recently used way of its set.
   logic [SETS-1:0] lru_q;

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         for (int i = 0; i < SETS; i++)
         begin
            sets_q[i] <= '0;
         end
         lru_q <= '0;
      end
      else
      begin
         case (op)
            OP_STORE_HIT:
            begin
               sets_q[index][way].data[word_sel] <= wdata;
               sets_q[index][way].dirty          <= 1'b1;
               lru_q[index]                      <= ~way;
            end
            OP_FILL_LO:
            begin
               sets_q[index][way].data[0] <= wdata;
            end
            OP_FILL_HI:
            begin
               sets_q[index][way].data[1] <= wdata;
               sets_q[index][way].valid   <= 1'b1;
               sets_q[index][way].dirty   <= 1'b0;
               sets_q[index][way].tag     <= wtag;
               lru_q[index]               <= ~way;
            end
            OP_CLEAN:   sets_q[index][way].dirty <= 1'b0;
            OP_TOUCH:   lru_q[index] <= ~way;
            default:    ;
         endcase
      end
   end

   // Read side of the selected set.
   assign way0 = sets_q[index][0];
   assign way1 = sets_q[index][1];
   assign lru  = lru_q[index[IDX_W-1:0]];

endmodule

`default_nettype wire

// File: dcache_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_lookup #(
   parameter int SETS = 8
) (
   input  dcache_pkg::tag_t    req_tag,
   input  logic                word_sel,
   input  dcache_pkg::line_t   way0,
   input  dcache_pkg::line_t   way1,
   input  logic                lru,
   output dcache_pkg::lookup_t result
);
   import dcache_pkg::*;

   // Tag, index, word select and byte bits must fill the address.
   if (TAG_W + $clog2(SETS) + BYTE_W + 1 != 32)
   begin : g_split_check
      $error("Address split does not cover 32 bits.");
   end

   logic  hit0;
   logic  hit1;
   line_t hit_line;
   line_t victim_line;

   assign hit0 = way0.valid && (way0.tag == req_tag);
   assign hit1 = way1.valid && (way1.tag == req_tag);

   assign hit_line    = hit1 ? way1 : way0;
   assign victim_line = lru ? way1 : way0;

   always_comb
   begin
      result              = '0;
      result.hit          = hit0 || hit1;
      result.hit_way      = hit1;
      result.victim_way   = lru;
      // An invalid victim never needs a write-back.
      result.victim_dirty = victim_line.valid && victim_line.dirty;
      result.victim_tag   = victim_line.tag;
      result.load_word    = hit_line.data[word_sel];
   end

endmodule

`default_nettype wire

// File: dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
   parameter int SETS = 8
) (
   input  logic                      CLK,
   input  logic                      nRST,
   input  dcache_pkg::cache_req_t    req,
   input  dcache_pkg::lookup_t       look,
   input  dcache_pkg::line_t         way0,
   input  dcache_pkg::line_t         way1,
   output logic [$clog2(SETS)-1:0]   index,
   output dcache_pkg::array_op_e     op,
   output logic                      way,
   output dcache_pkg::word_t         wdata,
   output dcache_pkg::tag_t          wtag,
   output logic                      word_sel,
   output dcache_pkg::cache_rsp_t    rsp,
   output dcache_pkg::mem_req_t      mem_req,
   input  dcache_pkg::mem_rsp_t      mem_rsp
);
   import dcache_pkg::*;

   localparam int IDX_W  = $clog2(SETS);
   // Way-slot counter with a done bit on top.
   localparam int SLOT_W = IDX_W + 2;

   ctrl_state_e        state, next_state;
   logic               victim_q, next_victim;
   logic               pending_q, next_pending;
   logic [SLOT_W-1:0]  scan_q, next_scan;
   logic signed [31:0] score_q, next_score;

   logic [IDX_W-1:0]   req_idx;
   line_t              victim_line;
   line_t              scan_line;

   function automatic word_t line_addr(tag_t t, logic [IDX_W-1:0] s, logic w);
      return {t, s, w, {BYTE_W{1'b0}}};
   endfunction

   assign wtag        = req.addr[31 -: TAG_W];
   assign word_sel    = req.addr[WSEL_BIT];
   assign req_idx     = req.addr[INDEX_LSB +: IDX_W];
   assign index       = (state inside {SCAN, FLUSH_LO, FLUSH_HI}) ? scan_q[IDX_W-1:0] : req_idx;
   assign victim_line = victim_q ? way1 : way0;
   assign scan_line   = scan_q[IDX_W] ? way1 : way0;

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         state     <= IDLE;
         victim_q  <= 1'b0;
         pending_q <= 1'b0;
         scan_q    <= '0;
         score_q   <= '0;
      end
      else
      begin
         state     <= next_state;
         victim_q  <= next_victim;
         pending_q <= next_pending;
         scan_q    <= next_scan;
         score_q   <= next_score;
      end
   end

   // --------------------------------------------------
   // Next state, array commands and memory bus.
   // --------------------------------------------------
   always_comb
   begin
      next_state   = state;
      next_victim  = victim_q;
      next_pending = pending_q;
      next_scan    = scan_q;
      next_score   = score_q;
      op           = OP_NOP;
      way          = victim_q;
      wdata        = mem_rsp.load;
      mem_req      = '0;
      rsp.hit      = 1'b0;
      rsp.load     = look.load_word;
      rsp.flushed  = 1'b0;
      case (state)
         IDLE:
         begin
            if (req.halt)
            begin
               next_state = SCAN;
            end
            else if (req.ren || req.wen)
            begin
               if (look.hit)
               begin
                  rsp.hit = 1'b1;
                  way     = look.hit_way;
                  wdata   = req.store;
                  op      = req.wen ? OP_STORE_HIT : OP_TOUCH;
                  // The hit that ends a refill was already scored as a miss.
                  if (!pending_q)
                  begin
                     next_score = score_q + 32'sd1;
                  end
                  next_pending = 1'b0;
               end
               else
               begin
                  next_score  = score_q - 32'sd1;
                  next_victim = look.victim_way;
                  next_state  = look.victim_dirty ? WB_LO : FILL_LO;
               end
            end
         end
         WB_LO, WB_HI:
         begin
            mem_req.wen   = 1'b1;
            mem_req.addr  = line_addr(look.victim_tag, req_idx, state == WB_HI);
            mem_req.store = victim_line.data[state == WB_HI];
            if (!mem_rsp.busy)
            begin
               next_state = (state == WB_LO) ? WB_HI : FILL_LO;
            end
         end
         FILL_LO, FILL_HI:
         begin
            mem_req.ren  = 1'b1;
            mem_req.addr = line_addr(wtag, req_idx, state == FILL_HI);
            if (!mem_rsp.busy)
            begin
               op = (state == FILL_LO) ? OP_FILL_LO : OP_FILL_HI;
               if (state == FILL_LO)
               begin
                  next_state = FILL_HI;
               end
               else
               begin
                  next_state   = IDLE;
                  next_pending = 1'b1;
               end
            end
         end
         SCAN:
         begin
            if (scan_q[SLOT_W-1])
            begin
               next_state = SCORE;
            end
            else if (scan_line.valid && scan_line.dirty)
            begin
               next_state = FLUSH_LO;
            end
            else
            begin
               next_scan = scan_q + 1'b1;
            end
         end
         FLUSH_LO, FLUSH_HI:
         begin
            mem_req.wen   = 1'b1;
            mem_req.addr  = line_addr(scan_line.tag, scan_q[IDX_W-1:0], state == FLUSH_HI);
            mem_req.store = scan_line.data[state == FLUSH_HI];
            if (!mem_rsp.busy)
            begin
               if (state == FLUSH_LO)
               begin
                  next_state = FLUSH_HI;
               end
               else
               begin
                  op         = OP_CLEAN;
                  way        = scan_q[IDX_W];
                  next_scan  = scan_q + 1'b1;
                  next_state = SCAN;
               end
            end
         end
         SCORE:
         begin
            mem_req.wen   = 1'b1;
            mem_req.addr  = COUNT_ADDR;
            mem_req.store = word_t'(score_q);
            if (!mem_rsp.busy)
            begin
               next_state = HALTED;
            end
         end
         HALTED:     rsp.flushed = 1'b1;
         default:    next_state = IDLE;
      endcase
   end

endmodule

`default_nettype wire

// File: dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
   parameter int SETS = 8
) (
   input  logic                   CLK,
   input  logic                   nRST,
   input  dcache_pkg::cache_req_t req,
   output dcache_pkg::cache_rsp_t rsp,
   output dcache_pkg::mem_req_t   mem_req,
   input  dcache_pkg::mem_rsp_t   mem_rsp
);
   import dcache_pkg::*;

   localparam int IDX_W = $clog2(SETS);

   logic [IDX_W-1:0] index;
   array_op_e        op;
   logic             way;
   word_t            wdata;
   tag_t             wtag;
   logic             word_sel;
   line_t            way0;
   line_t            way1;
   logic             lru;
   lookup_t          look;

   dcache_ctrl #(.SETS(SETS)) u_ctrl (
      .CLK      (CLK),
      .nRST     (nRST),
      .req      (req),
      .look     (look),
      .way0     (way0),
      .way1     (way1),
      .index    (index),
      .op       (op),
      .way      (way),
      .wdata    (wdata),
      .wtag     (wtag),
      .word_sel (word_sel),
      .rsp      (rsp),
      .mem_req  (mem_req),
      .mem_rsp  (mem_rsp)
   );

   // Compares the request tag against both ways of the set.
   dcache_lookup #(.SETS(SETS)) u_lookup (
      .req_tag  (wtag),
      .word_sel (word_sel),
      .way0     (way0),
      .way1     (way1),
      .lru      (lru),
      .result   (look)
   );

   dcache_arrays #(.SETS(SETS)) u_arrays (
      .CLK      (CLK),
      .nRST     (nRST),
      .index    (index),
      .op       (op),
      .way      (way),
      .wdata    (wdata),
      .wtag     (wtag),
      .word_sel (word_sel),
      .way0     (way0),
      .way1     (way1),
      .lru      (lru)
   );

endmodule

`default_nettype wire

// File: dcache_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_checker (
   input logic                   CLK,
   input logic                   nRST,
   input dcache_pkg::cache_rsp_t rsp,
   input dcache_pkg::mem_req_t   mem_req,
   input dcache_pkg::mem_rsp_t   mem_rsp
);

   a_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
      !(mem_req.ren && mem_req.wen))
      else $error("Memory read and write requested together.");

   // A stalled request must not move.
   a_hold: assert property (@(posedge CLK) disable iff (!nRST)
      ((mem_req.ren || mem_req.wen) && mem_rsp.busy) |=> $stable(mem_req))
      else $error("Memory request changed while busy was high.");

   a_flushed: assert property (@(posedge CLK) disable iff (!nRST)
      rsp.flushed |=> rsp.flushed)
      else $error("Flushed dropped before reset.");

endmodule

bind dcache_top dcache_checker u_checker (
   .CLK     (CLK),
   .nRST    (nRST),
   .rsp     (rsp),
   .mem_req (mem_req),
   .mem_rsp (mem_rsp)
);

`default_nettype wire

// File: dcache_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_monitor #(
   parameter int SETS = 8
) (
   input  logic                   CLK,
   input  logic                   nRST,
   input  dcache_pkg::cache_req_t req,
   input  dcache_pkg::cache_rsp_t rsp,
   input  dcache_pkg::mem_req_t   mem_req,
   input  dcache_pkg::mem_rsp_t   mem_rsp,
   input  dcache_pkg::word_t      exp_load,
   output int                     data_errs,
   output int                     bus_errs,
   output logic                   finished
);
   import dcache_pkg::*;

   localparam int IDX_W = $clog2(SETS);

   line_t    ref_line [SETS][2];
   logic     ref_lru [SETS];
   word_t    arch [word_t];
   word_t    seen [word_t];
   mem_req_t exp_q [$];
   int       score;
   logic     active;
   logic     halting;
   word_t    want;

   function automatic word_t addr_of(tag_t t, int s, int w);
      return {t, s[IDX_W-1:0], w[0], 2'b00};
   endfunction

   // Processor view of memory that includes data still held in dirty lines.
   function automatic word_t arch_read(word_t a);
      return arch.exists(a) ? arch[a] : (a ^ 32'h5a5a0000);
   endfunction

   task automatic expect_xfer(logic wr, word_t a, word_t d);
      mem_req_t t;
      t       = '0;
      t.ren   = !wr;
      t.wen   = wr;
      t.addr  = a;
      t.store = wr ? d : '0;
      exp_q.push_back(t);
   endtask

   task automatic start_access();
      int   s;
      int   w;
      tag_t t;
      logic hit;
      s   = int'(req.addr[INDEX_LSB +: IDX_W]);
      t   = req.addr[31 -: TAG_W];
      hit = 1'b0;
      w   = ref_lru[s];
      for (int i = 0; i < 2; i++)
      begin
         if (ref_line[s][i].valid && ref_line[s][i].tag == t)
         begin
            hit = 1'b1;
            w   = i;
         end
      end
      if (rsp.hit !== hit)
      begin
         $display("Fail %0t: hit is %b for address %h, expected %b",
                  $time, rsp.hit, req.addr, hit);
         data_errs++;
      end
      score = hit ? score + 1 : score - 1;
      if (!hit)
      begin
         // Dirty victim goes out first, then both words come in.
         if (ref_line[s][w].valid && ref_line[s][w].dirty)
         begin
            expect_xfer(1'b1, addr_of(ref_line[s][w].tag, s, 0), ref_line[s][w].data[0]);
            expect_xfer(1'b1, addr_of(ref_line[s][w].tag, s, 1), ref_line[s][w].data[1]);
         end
         expect_xfer(1'b0, addr_of(t, s, 0), '0);
         expect_xfer(1'b0, addr_of(t, s, 1), '0);
         ref_line[s][w].valid   = 1'b1;
         ref_line[s][w].dirty   = 1'b0;
         ref_line[s][w].tag     = t;
         ref_line[s][w].data[0] = arch_read(addr_of(t, s, 0));
         ref_line[s][w].data[1] = arch_read(addr_of(t, s, 1));
      end
      ref_lru[s] = (w == 0);
      if (req.wen)
      begin
         ref_line[s][w].data[req.addr[WSEL_BIT]] = req.store;
         ref_line[s][w].dirty = 1'b1;
         arch[{req.addr[31:2], 2'b00}] = req.store;
      end
      want = ref_line[s][w].data[req.addr[WSEL_BIT]];
   endtask

   task automatic finish_access();
      if (req.ren && (rsp.load !== want || want !== exp_load))
      begin
         $display("Fail %0t: load at %h returned %h, model %h, vector %h",
                  $time, req.addr, rsp.load, want, exp_load);
         data_errs++;
      end
   endtask

   // Flush order is way 0 of every set, then way 1, then the score.
   task automatic start_halt();
      for (int w = 0; w < 2; w++)
      begin
         for (int s = 0; s < SETS; s++)
         begin
            if (ref_line[s][w].valid && ref_line[s][w].dirty)
            begin
               expect_xfer(1'b1, addr_of(ref_line[s][w].tag, s, 0), ref_line[s][w].data[0]);
               expect_xfer(1'b1, addr_of(ref_line[s][w].tag, s, 1), ref_line[s][w].data[1]);
               ref_line[s][w].dirty = 1'b0;
            end
         end
      end
      if (word_t'(score) !== exp_load)
      begin
         $display("Fail %0t: model score %0d differs from vector score %h",
                  $time, score, exp_load);
         data_errs++;
      end
      expect_xfer(1'b1, COUNT_ADDR, word_t'(score));
      arch[COUNT_ADDR] = word_t'(score);
   endtask

   task automatic check_transfer();
      mem_req_t e;
      if (mem_req.wen)
         seen[mem_req.addr] = mem_req.store;
      if (exp_q.size() == 0)
      begin
         $display("Unexpected memory transfer to address %h at time %0t", mem_req.addr, $time);
         bus_errs++;
      end
      else
      begin
         e = exp_q.pop_front();
         if (mem_req.ren !== e.ren || mem_req.wen !== e.wen || mem_req.addr !== e.addr
             || (e.wen && mem_req.store !== e.store))
         begin
            $display("Fail %0t: memory %s %h data %h, expected %s %h data %h", $time,
                     mem_req.wen ? "write" : "read", mem_req.addr, mem_req.store,
                     e.wen ? "write" : "read", e.addr, e.store);
            bus_errs++;
         end
      end
   endtask

   task automatic final_check();
      word_t got;
      if (exp_q.size() != 0)
      begin
         $display("The flush ended with %0d memory transfers still missing", exp_q.size());
         bus_errs++;
      end
      foreach (arch[a])
      begin
         got = seen.exists(a) ? seen[a] : 32'hxxxx_xxxx;
         if (got !== arch[a])
         begin
            $display("Fail %0t: memory word %h holds %h, expected %h", $time, a, got, arch[a]);
            data_errs++;
         end
      end
   endtask

   // --------------------------------------------------
   // Sampling at the falling edge.
   // --------------------------------------------------
   always @(negedge CLK)
   begin
      if (!nRST)
      begin
         for (int s = 0; s < SETS; s++)
         begin
            ref_line[s][0] = '0;
            ref_line[s][1] = '0;
            ref_lru[s]     = 1'b0;
         end
         arch.delete();
         seen.delete();
         exp_q.delete();
         score     = 0;
         active    = 1'b0;
         halting   = 1'b0;
         finished  = 1'b0;
         data_errs = 0;
         bus_errs  = 0;
      end
      else
      begin
         if ((mem_req.ren || mem_req.wen) && !mem_rsp.busy)
            check_transfer();
         if (!active && !halting && req.halt)
         begin
            start_halt();
            halting = 1'b1;
         end
         else if (!active && !halting && (req.ren || req.wen))
         begin
            start_access();
            active = 1'b1;
         end
         if (active && rsp.hit)
         begin
            finish_access();
            active = 1'b0;
         end
         if (halting && rsp.flushed && !finished)
         begin
            final_check();
            finished = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
   import dcache_pkg::*;

   localparam int SETS    = 8;
   localparam int MAX_VEC = 64;

   logic       CLK;
   logic       nRST;
   cache_req_t req;
   cache_rsp_t rsp;
   mem_req_t   mem_req;
   mem_rsp_t   mem_rsp;
   logic       busy = 1'b0;
   word_t      load = '0;
   word_t      exp_load;
   int         data_errs;
   int         bus_errs;
   logic       finished;
   int         n_vec = 0;
   integer     seed = 32'h3bae1114;

   // Each vector holds an opcode, an address, store data and an expected value.
   word_t      vec [4*MAX_VEC];
   word_t      mem [word_t];

   assign mem_rsp = {busy, load};

   dcache_top #(.SETS(SETS)) uut (
      .CLK     (CLK),
      .nRST    (nRST),
      .req     (req),
      .rsp     (rsp),
      .mem_req (mem_req),
      .mem_rsp (mem_rsp)
   );

   dcache_monitor #(.SETS(SETS)) u_monitor (
      .CLK       (CLK),
      .nRST      (nRST),
      .req       (req),
      .rsp       (rsp),
      .mem_req   (mem_req),
      .mem_rsp   (mem_rsp),
      .exp_load  (exp_load),
      .data_errs (data_errs),
      .bus_errs  (bus_errs),
      .finished  (finished)
   );

   initial
   begin
      CLK = 1'b0;
      forever #4 CLK = ~CLK;
   end

   // --------------------------------------------------
   // Memory model.
   // --------------------------------------------------
   always @(negedge CLK)
   begin
      if (mem_req.wen && !busy)
         mem[mem_req.addr] = mem_req.store;
      if (mem_req.ren)
         load = mem.exists(mem_req.addr) ? mem[mem_req.addr] : (mem_req.addr ^ 32'h5a5a0000);
   end

   // Memory is busy for about one cycle in three.
   always @(posedge CLK)
   begin
      #1;
      busy = (($random(seed) % 3) == 0);
   end

   task automatic report_and_finish(input logic timed_out);
      $display("Errors: %0d data, %0d bus, %0d timeout", data_errs, bus_errs, timed_out);
      if (data_errs == 0 && bus_errs == 0 && !timed_out)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   endtask

   task automatic wait_for_hit();
      do
         @(negedge CLK);
      while (rsp.hit !== 1'b1);
   endtask

   // --------------------------------------------------
   // Stimulus.
   // --------------------------------------------------
   initial
   begin
      int count;
      req      = '0;
      exp_load = '0;
      nRST     = 1'b0;
      $readmemh("dcache_vectors.txt", vec);
      count = 0;
      while (count < MAX_VEC - 1 && vec[4*count] !== 32'h2)
         count++;
      n_vec = count + 1;
      repeat (10) @(posedge CLK);
      #1 nRST = 1'b1;
      for (int i = 0; i < n_vec; i++)
      begin
         @(posedge CLK);
         #1;
         req       = '0;
         req.ren   = (vec[4*i] == 32'h0);
         req.wen   = (vec[4*i] == 32'h1);
         req.halt  = (vec[4*i] == 32'h2);
         req.addr  = vec[4*i+1];
         req.store = vec[4*i+2];
         exp_load  = vec[4*i+3];
         if (!req.halt)
            wait_for_hit();
      end
      wait (finished === 1'b1);
      // The cache sits halted for a while so that flushed is seen to hold.
      repeat (10) @(posedge CLK);
      report_and_finish(1'b0);
   end

   // Watchdog.
   initial
   begin
      wait (n_vec > 0);
      repeat (10 + 200 * n_vec + 2000) @(posedge CLK);
      $display("Timeout: the run did not finish within %0d cycles.", 10 + 200 * n_vec + 2000);
      report_and_finish(1'b1);
   end

endmodule

`default_nettype wire

// File: dcache_vectors.txt
// Columns (hex): op addr store expect, op 0 load, 1 store, 2 halt.
// expect is the load data, or the final hit score for halt.
0 00000008 00000000 5a5a0008
0 00000008 00000000 5a5a0008
0 0000000c 00000000 5a5a000c
1 0000000c dead0001 00000000
0 0000000c 00000000 dead0001
0 00000048 00000000 5a5a0048
0 00000088 00000000 5a5a0088
0 0000000c 00000000 dead0001
1 00000010 cafe0010 00000000
1 00000014 cafe0014 00000000
1 00000100 12345678 00000000
0 00000104 00000000 5a5a0104
0 00003100 00000000 5a5a3100
1 00000090 0bad0090 00000000
0 000000d0 00000000 5a5a00d0
0 00000014 00000000 cafe0014
1 0000003c 77770003 00000000
2 00000000 00000000 fffffffb

// File: dcache.f
dcache_pkg.sv
dcache_arrays.sv
dcache_lookup.sv
dcache_ctrl.sv
dcache_top.sv
dcache_checker.sv
dcache_monitor.sv
dcache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb -f dcache.f -o sim_dcache
./obj_dir/sim_dcache | tee sim.log

if grep -q "Done: errors found" sim.log; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation passed"
